/* hdl/clk_ctrl_config.svh */
`ifndef CLK_CTRL_CONFIG_SVH
`define CLK_CTRL_CONFIG_SVH

// ----------------------------------------
// Comparator clock phase
// ----------------------------------------
// Phase code from the slow control
`define CMP_CODE_W 5
// Fine step count inside the phase-shift PLL
`define CMP_PHASE_W 11
// 56 steps per VCO period, 24 VCO periods per 25 ns
`define CMP_STEPS 1344
// Highest code value, maps to a full cycle
`define CMP_CODE_MAX 31
// Cycles to wait after done, lets the change flag catch up
`define PS_SETTLE 3

// ----------------------------------------
// Sampling clock and resync
// ----------------------------------------
`define SAMP_RST_DEPTH 8
`define US_PRESCALE 40
`define DSR_HOLD_TICKS 100

`endif

/* hdl/cmp_phase_pkg.sv */
`default_nettype none

package cmp_phase_pkg;

	// ----------------------------------------
	// Dynamic phase-shift FSM states
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		st_idle      = 3'd0,
		// Hold off until the PLL reports lock
		st_wait_lock = 3'd1,
		// Single cycle, PLL enable pulse
		st_step      = 3'd2,
		st_wait_done = 3'd3,
		st_settle    = 3'd4
	} ps_state_e;

	// ----------------------------------------
	// Tracker to FSM command
	// ----------------------------------------
	typedef struct packed
	{
		// Target differs from tracked phase
		logic change;
		// Step direction, 1 moves the phase up
		logic inc;
		// Phase-shift reset, board or JTAG
		logic rst;
	} ps_cmd_t;

endpackage

`default_nettype wire

/* hdl/samp_clk_pkg.sv */
`default_nettype none

package samp_clk_pkg;

	// ----------------------------------------
	// SAMP_CLK_PHASE word
	// ----------------------------------------
	// Raw view for registers and compares,
	// field view for the clock mux selects
	typedef union packed
	{
		logic [2:0] raw;
		struct packed
		{
			// 20 MHz half, picks the PLL input
			logic       half;
			// 45 degree tap of the sampling PLL
			logic [1:0] tap;
		} fields;
	} samp_phase_u;

	// ----------------------------------------
	// Sampling clock control outputs
	// ----------------------------------------
	typedef struct packed
	{
		logic cap_phase;
		logic mmcm_rst;
		logic in_sel;
		logic c20_sel;
	} samp_ctrl_t;

endpackage

`default_nettype wire

/* hdl/cmp_phase_tracker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module cmp_phase_tracker
	import cmp_phase_pkg::*;
(
	input  wire logic                   CLK40,
	input  wire logic                   RST,
	input  wire logic                   jtag_rst,
	input  wire logic [`CMP_CODE_W-1:0] code,
	input  wire logic                   ps_en,
	output ps_cmd_t                     cmd,
	output logic                        phs_change,
	output logic [`CMP_PHASE_W-1:0]     cur_phase
);

	localparam int ROM_DEPTH = 1 << `CMP_CODE_W;
	localparam int PW = `CMP_PHASE_W;

	logic [PW-1:0] cmp_rom [ROM_DEPTH];
	logic [PW-1:0] target;
	logic          ps_rst;
	logic          inc;
	logic          change_m1;

	// Either reset also restarts the PLL phase
	assign ps_rst = RST | jtag_rst;

	// ----------------------------------------
	// Code to fine step table
	// ----------------------------------------
	// 32 codes spread over 1344 steps, rounded to nearest
	for (genvar i = 0; i < ROM_DEPTH; i++)
	begin : g_rom
		assign cmp_rom[i] = PW'((i * `CMP_STEPS + `CMP_CODE_MAX / 2) / `CMP_CODE_MAX);
	end

	// Target follows the code one cycle later
	always_ff @(posedge CLK40)
	begin
		target <= cmp_rom[code];
	end

	// Direction and change flags, then a second stage for the FSM
	always_ff @(posedge CLK40 or posedge ps_rst)
	begin
		if (ps_rst)
		begin
			inc        <= 1'b0;
			change_m1  <= 1'b0;
			phs_change <= 1'b0;
		end
		else
		begin
			inc        <= (target > cur_phase);
			change_m1  <= (target != cur_phase);
			// Extra delay so a fresh step is seen before the next decision
			phs_change <= change_m1;
		end
	end

	// ----------------------------------------
	// Phase presumed inside the PLL
	// ----------------------------------------
	// PLL comes out of reset at phase 0
	always_ff @(posedge CLK40 or posedge ps_rst)
	begin
		if (ps_rst)
			cur_phase <= '0;
		else if (ps_en)
		begin
			if (inc)
				cur_phase <= cur_phase + 1'b1;
			else
				cur_phase <= cur_phase - 1'b1;
		end
	end

	always_comb
	begin
		cmd.change = change_m1;
		cmd.inc    = inc;
		cmd.rst    = ps_rst;
	end

endmodule

`default_nettype wire

/* hdl/dyn_phase_shift_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module dyn_phase_shift_fsm
	import cmp_phase_pkg::*;
(
	input  wire logic    CLK40,
	input  wire ps_cmd_t cmd,
	input  wire logic    phs_change,
	input  wire logic    locked,
	input  wire logic    ps_done,
	output logic         ps_en,
	output logic         ps_incdec,
	output logic         busy,
	output ps_state_e    state
);

	localparam int SET_W = $clog2(`PS_SETTLE + 1);

	ps_state_e  next_state;
	logic [SET_W-1:0] settle_cnt;
	logic       fsm_rst;
	logic       settle_last;

	assign fsm_rst = cmd.rst;
	assign settle_last = (settle_cnt == SET_W'(`PS_SETTLE - 1));

	// ----------------------------------------
	// State register
	// ----------------------------------------
	always_ff @(posedge CLK40 or posedge fsm_rst)
	begin
		if (fsm_rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	// Settle counter, cleared outside the settle state
	always_ff @(posedge CLK40 or posedge fsm_rst)
	begin
		if (fsm_rst)
			settle_cnt <= '0;
		else if (state == st_settle)
			settle_cnt <= settle_cnt + 1'b1;
		else
			settle_cnt <= '0;
	end

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (phs_change)
					next_state = st_wait_lock;
			st_wait_lock:
				// No stepping while the PLL is out of lock
				if (locked)
				begin
					// Target may have moved back meanwhile
					if (cmd.change)
						next_state = st_step;
					else
						next_state = st_idle;
				end
			st_step:
				next_state = st_wait_done;
			st_wait_done:
				if (ps_done)
					next_state = st_settle;
			st_settle:
				if (settle_last)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	// One enable pulse per step, direction taken in the same cycle
	assign ps_en     = (state == st_step);
	assign ps_incdec = (state == st_step) & cmd.inc;
	assign busy      = (state != st_idle);

endmodule

`default_nettype wire

/* hdl/samp_clk_phase_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module samp_clk_phase_ctrl
	import samp_clk_pkg::*;
(
	input  wire logic        CLK40,
	input  wire logic        RST,
	input  wire logic        resync,
	input  wire logic        samp_phs_chng,
	input  wire samp_phase_u phase,
	output samp_ctrl_t       ctrl
);

	logic rst_d1;
	logic rst_d2;
	logic trl_edg_rst;
	logic resync_d1;
	logic lead_edg;
	logic lead_edg_d1;
	logic cap_phase;
	logic clk20_phase;
	logic c20_sel;
	logic pipe_in;
	logic [`SAMP_RST_DEPTH-1:0] rst_pipe;

	// ----------------------------------------
	// Edge detection
	// ----------------------------------------
	// Reset release, two cycles wide
	assign trl_edg_rst = ~RST & rst_d2;
	// Resync rising, one cycle wide
	assign lead_edg = resync & ~resync_d1;

	// Copies of the reset itself
	always_ff @(posedge CLK40)
	begin
		rst_d1 <= RST;
		rst_d2 <= rst_d1;
	end

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			resync_d1   <= 1'b0;
			lead_edg_d1 <= 1'b0;
			cap_phase   <= 1'b0;
		end
		else
		begin
			resync_d1   <= resync;
			lead_edg_d1 <= lead_edg;
			// Two cycles on resync so the select sees both halves
			cap_phase   <= lead_edg | lead_edg_d1 | trl_edg_rst | samp_phs_chng;
		end
	end

	// ----------------------------------------
	// 20 MHz half select
	// ----------------------------------------
	// Toggle aligned to resync
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			clk20_phase <= 1'b0;
		else if (lead_edg)
			clk20_phase <= 1'b0;
		else
			clk20_phase <= ~clk20_phase;
	end

	// Half captured while the strobe is high
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			c20_sel <= 1'b0;
		else if (cap_phase)
			c20_sel <= clk20_phase;
	end

	// ----------------------------------------
	// Sampling PLL reset stretcher
	// ----------------------------------------
	assign pipe_in = lead_edg | trl_edg_rst | cap_phase | samp_phs_chng;

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			rst_pipe <= '0;
		else
			rst_pipe <= {rst_pipe[`SAMP_RST_DEPTH-2:0], pipe_in};
	end

	always_comb
	begin
		ctrl.cap_phase = cap_phase;
		// Held until the last trigger leaves the pipe
		ctrl.mmcm_rst  = |rst_pipe;
		// PLL input half, flipped by the captured 20 MHz phase
		ctrl.in_sel    = phase.fields.half ^ c20_sel;
		ctrl.c20_sel   = c20_sel;
	end

endmodule

`default_nettype wire

/* hdl/dsr_holdoff.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module dsr_holdoff
(
	input  wire logic CLK40,
	input  wire logic RST,
	input  wire logic cap_phase,
	output logic      dsr_resync
);

	localparam int PRE_W = $clog2(`US_PRESCALE);
	localparam int HO_W  = $clog2(`DSR_HOLD_TICKS + 1);

	logic [PRE_W-1:0] pre_cnt;
	logic             us_tick;
	logic [HO_W-1:0]  ho_tmr;
	logic             ho_done;

	// ----------------------------------------
	// 1 MHz tick, free running
	// ----------------------------------------
	assign us_tick = (pre_cnt == PRE_W'(`US_PRESCALE - 1));

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			pre_cnt <= '0;
		else if (us_tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	// ----------------------------------------
	// 100 us holdoff
	// ----------------------------------------
	assign ho_done = (ho_tmr == HO_W'(`DSR_HOLD_TICKS));

	// Counts ticks while held, restarts on a new capture
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			ho_tmr <= '0;
		else if (!dsr_resync || cap_phase)
			ho_tmr <= '0;
		else if (us_tick && !ho_done)
			ho_tmr <= ho_tmr + 1'b1;
	end

	// Capture wins over the end of count
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
			dsr_resync <= 1'b0;
		else if (cap_phase)
			dsr_resync <= 1'b1;
		else if (ho_done)
			dsr_resync <= 1'b0;
	end

endmodule

`default_nettype wire

/* hdl/clock_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module clock_ctrl_top
	import cmp_phase_pkg::*, samp_clk_pkg::*;
(
	input  wire logic                   CLK40,
	input  wire logic                   RST,
	// Comparator phase control
	input  wire logic [`CMP_CODE_W-1:0] cmp_clk_phase,
	input  wire logic                   cmp_jtag_rst,
	// Sampling phase control
	input  wire samp_phase_u            samp_phase,
	input  wire logic                   samp_phs_chng,
	input  wire logic                   resync,
	// Phase-shift PLL status
	input  wire logic                   ps_done,
	input  wire logic                   trg_mmcm_lock,
	// Phase-shift PLL control
	output logic                        ps_en,
	output logic                        ps_incdec,
	output logic                        ps_rst,
	// Status
	output logic                        cmp_phs_change,
	output logic                        cmp_phs_busy,
	output ps_state_e                   cmp_phs_state,
	output logic [`CMP_PHASE_W-1:0]     cmp_phase_cur,
	output samp_ctrl_t                  samp_ctrl,
	output logic                        dsr_resync
);

	ps_cmd_t ps_cmd;

	// Phase-shift reset also goes out to the PLL
	assign ps_rst = ps_cmd.rst;

	// ----------------------------------------
	// Comparator clock phase
	// ----------------------------------------
	cmp_phase_tracker cmp_phase_tracker_inst
	(
		.CLK40      (CLK40),
		.RST        (RST),
		.jtag_rst   (cmp_jtag_rst),
		.code       (cmp_clk_phase),
		.ps_en      (ps_en),
		.cmd        (ps_cmd),
		.phs_change (cmp_phs_change),
		.cur_phase  (cmp_phase_cur)
	);

	dyn_phase_shift_fsm dyn_phase_shift_fsm_inst
	(
		.CLK40      (CLK40),
		.cmd        (ps_cmd),
		.phs_change (cmp_phs_change),
		.locked     (trg_mmcm_lock),
		.ps_done    (ps_done),
		.ps_en      (ps_en),
		.ps_incdec  (ps_incdec),
		.busy       (cmp_phs_busy),
		.state      (cmp_phs_state)
	);

	// ----------------------------------------
	// Sampling clock and resync holdoff
	// ----------------------------------------
	samp_clk_phase_ctrl samp_clk_phase_ctrl_inst
	(
		.CLK40         (CLK40),
		.RST           (RST),
		.resync        (resync),
		.samp_phs_chng (samp_phs_chng),
		.phase         (samp_phase),
		.ctrl          (samp_ctrl)
	);

	dsr_holdoff dsr_holdoff_inst
	(
		.CLK40      (CLK40),
		.RST        (RST),
		.cap_phase  (samp_ctrl.cap_phase),
		.dsr_resync (dsr_resync)
	);

endmodule

`default_nettype wire

/* test/clock_ctrl_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_sva
(
	input wire logic CLK40,
	input wire logic rst,
	input wire logic ps_en,
	input wire logic ps_done,
	input wire logic trigger,
	input wire logic mmcm_rst
);

	logic       pending;
	logic [3:0] since_trig;

	// Step issued, done not yet back
	always_ff @(posedge CLK40 or posedge rst)
	begin
		if (rst)
			pending <= 1'b0;
		else if (ps_en)
			pending <= 1'b1;
		else if (ps_done)
			pending <= 1'b0;
	end

	// Cycles since the last stretcher trigger, saturating
	always_ff @(posedge CLK40 or posedge rst)
	begin
		if (rst)
			since_trig <= 4'hf;
		else if (trigger)
			since_trig <= '0;
		else if (since_trig != 4'hf)
			since_trig <= since_trig + 4'd1;
	end

	a_en_pulse: assert property (@(posedge CLK40) disable iff (rst) ps_en |=> !ps_en)
		else $error("ps_en wider than one cycle");

	a_en_after_done: assert property (@(posedge CLK40) disable iff (rst) ps_en |-> !pending)
		else $error("ps_en between a step and its done");

	a_rst_fall: assert property (@(posedge CLK40) disable iff (rst)
		(since_trig >= 4'd10) |-> !mmcm_rst)
		else $error("mmcm_rst still high 10 cycles after the last trigger");

endmodule

// Phase-shift exchange, stretcher inputs tied off
bind dyn_phase_shift_fsm clock_ctrl_sva ps_sva_inst
(
	.CLK40    (CLK40),
	.rst      (cmd.rst),
	.ps_en    (ps_en),
	.ps_done  (ps_done),
	.trigger  (1'b0),
	.mmcm_rst (1'b0)
);

// Sampling reset pipe, PLL exchange tied off
bind samp_clk_phase_ctrl clock_ctrl_sva samp_sva_inst
(
	.CLK40    (CLK40),
	.rst      (RST),
	.ps_en    (1'b0),
	.ps_done  (1'b0),
	.trigger  (pipe_in),
	.mmcm_rst (ctrl.mmcm_rst)
);

`default_nettype wire

/* test/clock_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "clk_ctrl_config.svh"

module clock_ctrl_tb
	import cmp_phase_pkg::*, samp_clk_pkg::*;
();

	localparam int RESET_CYCLES = 8;
	localparam int NUM_ROWS     = 7;
	// Worst step, 5 cycles of done delay plus FSM overhead
	localparam int STEP_BUDGET  = 13;
	localparam int HOLD_CYCLES  = `DSR_HOLD_TICKS * `US_PRESCALE;
	localparam int HOLD_BUDGET  = HOLD_CYCLES + 200;

	typedef enum logic [1:0]
	{
		k_code,
		k_lock_drop,
		k_resync,
		k_samp_chng
	} row_kind_e;

	// Value is a phase code, expected a phase, select or length
	typedef struct packed
	{
		row_kind_e   kind;
		logic [15:0] value;
		logic [15:0] expected;
	} stim_row_t;

	// ----------------------------------------
	// DUT signals
	// ----------------------------------------
	logic                   CLK40;
	logic                   RST;
	logic [`CMP_CODE_W-1:0] cmp_clk_phase;
	logic                   cmp_jtag_rst;
	samp_phase_u            samp_phase;
	logic                   samp_phs_chng;
	logic                   resync;
	logic                   ps_done = 1'b0;
	logic                   trg_mmcm_lock;
	logic                   ps_en;
	logic                   ps_incdec;
	logic                   ps_rst;
	logic                   cmp_phs_change;
	logic                   cmp_phs_busy;
	ps_state_e              cmp_phs_state;
	logic [`CMP_PHASE_W-1:0] cmp_phase_cur;
	samp_ctrl_t             samp_ctrl;
	logic                   dsr_resync;

	stim_row_t   stim_tab [NUM_ROWS];
	int          err_cnt = 0;
	int          check_cnt = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 0;

	// PLL model state
	logic [31:0] lfsr = 32'hcd199979;
	int          model_phase = 0;
	int          done_cnt = 0;
	int          inc_pulses = 0;
	int          dec_pulses = 0;

	clock_ctrl_top clock_ctrl_top_inst
	(
		.CLK40          (CLK40),
		.RST            (RST),
		.cmp_clk_phase  (cmp_clk_phase),
		.cmp_jtag_rst   (cmp_jtag_rst),
		.samp_phase     (samp_phase),
		.samp_phs_chng  (samp_phs_chng),
		.resync         (resync),
		.ps_done        (ps_done),
		.trg_mmcm_lock  (trg_mmcm_lock),
		.ps_en          (ps_en),
		.ps_incdec      (ps_incdec),
		.ps_rst         (ps_rst),
		.cmp_phs_change (cmp_phs_change),
		.cmp_phs_busy   (cmp_phs_busy),
		.cmp_phs_state  (cmp_phs_state),
		.cmp_phase_cur  (cmp_phase_cur),
		.samp_ctrl      (samp_ctrl),
		.dsr_resync     (dsr_resync)
	);

	// 20 ns period
	initial
	begin
		CLK40 = 1'b0;
		forever #10 CLK40 = ~CLK40;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	// Code to fine step, rounded to nearest
	function automatic int phase_of_code(input int code);
		return (code * `CMP_STEPS + `CMP_CODE_MAX / 2) / `CMP_CODE_MAX;
	endfunction

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// Right-shifting Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	task automatic compare_int(input string what, input int got, input int exp);
		check_cnt++;
		if (got != exp)
		begin
			err_cnt++;
			$display("ERROR: t=%0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		check_cnt++;
		if (!cond)
		begin
			err_cnt++;
			$display("ERROR: t=%0t %s", $time, what);
		end
	endtask

	task automatic set_row(input int r, input row_kind_e kind, input int value, input int exp);
		stim_tab[r].kind     = kind;
		stim_tab[r].value    = 16'(value);
		stim_tab[r].expected = 16'(exp);
	endtask

	task automatic build_table;
		set_row(0, k_code, 31, phase_of_code(31));
		set_row(1, k_code, 0, phase_of_code(0));
		set_row(2, k_code, 16, phase_of_code(16));
		set_row(3, k_code, 5, phase_of_code(5));
		set_row(4, k_lock_drop, 20, phase_of_code(20));
		// Isolated resync edge leaves the select at 1
		set_row(5, k_resync, 0, 1);
		set_row(6, k_samp_chng, 0, HOLD_CYCLES);
	endtask

	// Cycle budget of the whole table, doubled for margin
	function automatic int test_budget();
		int total;
		int prev;
		total = RESET_CYCLES + 20;
		prev  = 0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			if (stim_tab[r].kind == k_code || stim_tab[r].kind == k_lock_drop)
			begin
				total += STEP_BUDGET * abs_diff(stim_tab[r].expected, prev) + 100;
				prev = stim_tab[r].expected;
			end
			else
				total += HOLD_BUDGET;
		end
		return total * 2;
	endfunction

	// ----------------------------------------
	// Phase-shift PLL model
	// ----------------------------------------
	// Done after 2 to 5 cycles, own phase count
	always @(posedge CLK40)
	begin
		logic [1:0] dly;
		logic       pending;
		ps_done <= 1'b0;
		pending = (done_cnt != 0) || ps_done;
		if (ps_rst)
		begin
			model_phase = 0;
			done_cnt    = 0;
		end
		else
		begin
			if (done_cnt != 0)
			begin
				if (done_cnt == 1)
					ps_done <= 1'b1;
				done_cnt = done_cnt - 1;
			end
			if (ps_en)
			begin
				if (pending)
				begin
					err_cnt++;
					$display("ERROR: t=%0t ps_en raised before the previous done", $time);
				end
				if (ps_incdec)
				begin
					model_phase++;
					inc_pulses++;
				end
				else
				begin
					model_phase--;
					dec_pulses++;
				end
				// One LFSR step per delay bit
				lfsr   = lfsr_next(lfsr);
				dly[0] = lfsr[0];
				lfsr   = lfsr_next(lfsr);
				dly[1] = lfsr[0];
				done_cnt = 2 + int'(dly);
			end
		end
	end

	// ----------------------------------------
	// Row tasks
	// ----------------------------------------
	// New target reaches the change flag in 3 cycles
	task automatic wait_converged;
		repeat (4) @(negedge CLK40);
		while (cmp_phs_busy || cmp_phs_change)
			@(negedge CLK40);
	endtask

	task automatic run_code_row(input int code, input int exp_phase, input int prev_phase,
		input bit drop_lock);
		int inc_start;
		int dec_start;
		int steps;
		inc_start = inc_pulses;
		dec_start = dec_pulses;
		steps     = abs_diff(exp_phase, prev_phase);
		if (drop_lock)
		begin
			@(posedge CLK40);
			trg_mmcm_lock <= 1'b0;
		end
		@(posedge CLK40);
		cmp_clk_phase <= `CMP_CODE_W'(code);
		if (drop_lock)
		begin
			// FSM parks in wait_lock without stepping
			repeat (20) @(negedge CLK40);
			compare_int("busy while unlocked", cmp_phs_busy, 1);
			compare_int("state while unlocked", int'(cmp_phs_state), int'(st_wait_lock));
			compare_int("ps_en pulses while unlocked",
				inc_pulses + dec_pulses - inc_start - dec_start, 0);
			@(posedge CLK40);
			trg_mmcm_lock <= 1'b1;
		end
		wait_converged();
		compare_int("cmp_phase_cur", cmp_phase_cur, exp_phase);
		compare_int("PLL model phase", model_phase, exp_phase);
		if (exp_phase >= prev_phase)
		begin
			compare_int("increment pulses", inc_pulses - inc_start, steps);
			compare_int("decrement pulses", dec_pulses - dec_start, 0);
		end
		else
		begin
			compare_int("increment pulses", inc_pulses - inc_start, 0);
			compare_int("decrement pulses", dec_pulses - dec_start, steps);
		end
	endtask

	task automatic run_resync_row(input int exp_sel);
		int          first_hi;
		int          first_lo;
		samp_phase_u sp;
		first_hi = -1;
		first_lo = -1;
		@(posedge CLK40);
		resync <= 1'b1;
		// Fixed window, the stretcher is 8 deep
		for (int i = 1; i <= 20; i++)
		begin
			@(negedge CLK40);
			if (first_hi < 0 && samp_ctrl.mmcm_rst)
				first_hi = i;
			else if (first_hi >= 0 && first_lo < 0 && !samp_ctrl.mmcm_rst)
				first_lo = i;
		end
		expect_true(first_hi >= 0, "mmcm_rst never went high after the resync edge");
		expect_true(first_lo >= 0 && first_lo <= 12,
			"mmcm_rst did not fall within 12 cycles of the resync edge");
		compare_int("c20_sel after resync", samp_ctrl.c20_sel, exp_sel);
		@(posedge CLK40);
		resync <= 1'b0;
		// Both halves, input select is the inverse
		for (int h = 0; h < 2; h++)
		begin
			sp.raw        = '0;
			sp.fields.half = h[0];
			sp.fields.tap  = 2'(h + 1);
			@(posedge CLK40);
			samp_phase <= sp;
			@(negedge CLK40);
			compare_int("in_sel", samp_ctrl.in_sel, int'(!h[0]));
		end
		@(posedge CLK40);
		samp_phase <= '0;
		// Let this holdoff run out
		while (dsr_resync)
			@(negedge CLK40);
	endtask

	task automatic run_holdoff_row(input int exp_cycles);
		int hi_cycles;
		bit saw_rst;
		hi_cycles = 0;
		saw_rst   = 1'b0;
		while (dsr_resync)
			@(negedge CLK40);
		@(posedge CLK40);
		samp_phs_chng <= 1'b1;
		@(posedge CLK40);
		samp_phs_chng <= 1'b0;
		@(negedge CLK40);
		while (!dsr_resync)
		begin
			saw_rst |= samp_ctrl.mmcm_rst;
			@(negedge CLK40);
		end
		while (dsr_resync)
		begin
			saw_rst |= samp_ctrl.mmcm_rst;
			hi_cycles++;
			@(negedge CLK40);
		end
		expect_true(saw_rst, "mmcm_rst did not pulse on the sample phase change");
		expect_true(hi_cycles >= exp_cycles - `US_PRESCALE &&
			hi_cycles <= exp_cycles + `US_PRESCALE,
			$sformatf("dsr_resync held %0d cycles, outside the holdoff window", hi_cycles));
	endtask

	task automatic check_reset_values;
		compare_int("ps_en in reset", ps_en, 0);
		compare_int("ps_incdec in reset", ps_incdec, 0);
		compare_int("ps_rst in reset", ps_rst, 1);
		compare_int("cmp_phs_change in reset", cmp_phs_change, 0);
		compare_int("cmp_phs_busy in reset", cmp_phs_busy, 0);
		compare_int("cmp_phs_state in reset", int'(cmp_phs_state), int'(st_idle));
		compare_int("cmp_phase_cur in reset", cmp_phase_cur, 0);
		compare_int("samp_ctrl in reset", int'(samp_ctrl), 0);
		compare_int("dsr_resync in reset", dsr_resync, 0);
	endtask

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	initial
	begin
		while (cycle_limit == 0 || cycle_cnt < cycle_limit)
		begin
			@(posedge CLK40);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the DUT did not reach the expected state", cycle_cnt);
		$display("Simulation failed");
		$finish;
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		int prev_phase;
		RST           = 1'b1;
		cmp_clk_phase = '0;
		cmp_jtag_rst  = 1'b0;
		samp_phase    = '0;
		samp_phs_chng = 1'b0;
		resync        = 1'b0;
		trg_mmcm_lock = 1'b1;
		build_table();
		cycle_limit = test_budget();
		prev_phase  = 0;

		repeat (RESET_CYCLES - 1) @(posedge CLK40);
		@(negedge CLK40);
		check_reset_values();
		@(posedge CLK40);
		RST <= 1'b0;
		@(negedge CLK40);
		compare_int("ps_rst after reset", ps_rst, 0);

		for (int r = 0; r < NUM_ROWS; r++)
		begin
			case (stim_tab[r].kind)
				k_code:
					run_code_row(stim_tab[r].value, stim_tab[r].expected, prev_phase, 1'b0);
				k_lock_drop:
					run_code_row(stim_tab[r].value, stim_tab[r].expected, prev_phase, 1'b1);
				k_resync:
					run_resync_row(stim_tab[r].expected);
				default:
					run_holdoff_row(stim_tab[r].expected);
			endcase
			if (stim_tab[r].kind == k_code || stim_tab[r].kind == k_lock_drop)
				prev_phase = stim_tab[r].expected;
		end

		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/cmp_phase_pkg.sv
hdl/samp_clk_pkg.sv
hdl/cmp_phase_tracker.sv
hdl/dyn_phase_shift_fsm.sv
hdl/samp_clk_phase_ctrl.sv
hdl/dsr_holdoff.sv
hdl/clock_ctrl_top.sv
test/clock_ctrl_sva.sv
test/clock_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the clock control testbench

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module clock_ctrl_tb -o clock_ctrl_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/clock_ctrl_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation run returned status $sim_status"
	exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "Simulation passed" "$SIM_LOG"; then
	echo "No result line found in $SIM_LOG"
	exit 1
fi
exit 0
